//--- files.f
hdl/rv_pkg.sv
hdl/singlecycle_control.sv
hdl/alu.sv
hdl/regfile.sv
hdl/imm_gen.sv
hdl/branch_unit.sv
hdl/singlecycle_core.sv
testbench/core_asserts.sv
testbench/tb_core.sv

//--- run.sh
#!/bin/sh
# builds tb_core with Verilator and runs it, the log decides the result
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_core -f files.f \
  && ./obj_dir/Vtb_core 2>&1 | tee sim.log
grep -q '^\*\* PASS \*\*$' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- testbench/tb_core.sv
//----------------------------------------------------------
// testbench for singlecycle_core with reset_vector 0x100
// program sits at 0x100 upward, data memory is 64 words
// pc and every data memory request are compared with an instruction-set model
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_core;

  localparam logic [31:0] reset_vector = 32'h100;
  localparam int          num_steps    = 120;

  logic              clock;
  logic              arst_n;
  logic [31:0]       inst_addr;
  logic [31:0]       inst;
  rv_pkg::dmem_req_t dmem_req;
  logic [31:0]       dmem_rdata;

  logic [31:0] imem [256];
  logic [31:0] dmem [64];
  logic [31:0] sh_dmem [64];
  logic [31:0] sh_regs [32];
  logic [31:0] sh_pc;
  logic [7:0]  emit_idx;
  logic [11:0] store_off;

  singlecycle_core #(.reset_vector(reset_vector)) singlecycle_core_i (
    .clock     (clock),
    .arst_n    (arst_n),
    .inst_addr (inst_addr),
    .inst      (inst),
    .dmem_req  (dmem_req),
    .dmem_rdata(dmem_rdata)
  );

  bind singlecycle_core core_asserts core_asserts_i (
    .clock(clock), .arst_n(arst_n), .inst(inst), .inst_addr(inst_addr),
    .ctl(ctl), .dmem_req(dmem_req)
  );

  // zero-wait memories
  assign inst       = imem[inst_addr[9:2]];
  assign dmem_rdata = dmem[dmem_req.addr[7:2]];

  always @(posedge clock) begin
    if (arst_n && dmem_req.write_enable) dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
  end

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clock);
    #1 arst_n = 1'b1;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[emit_idx] = word;
    emit_idx++;
  endtask

  // each stored result goes to the next free data word
  task automatic emit_store(input logic [4:0] rs);
    emit(enc_s(store_off, rs, 5'd0));
    store_off += 12'd4;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) abort_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  // instruction-set model on the shadow state, gives next pc and data request
  function automatic void ref_step(input logic [31:0] ins, output logic [31:0] npc,
                                   output rv_pkg::dmem_req_t st);
    logic [31:0] a, b, y, res, ea;
    logic [31:0] imm_i, imm_s, imm_b, imm_j;
    logic        wr, alt, taken;
    a     = sh_regs[ins[19:15]];
    b     = sh_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    npc   = sh_pc + 32'd4;
    st    = '0;
    res   = '0;
    wr    = 1'b1;
    taken = 1'b0;
    case (ins[6:0])
      rv_pkg::OPC_LUI:   res = {ins[31:12], 12'h000};
      rv_pkg::OPC_AUIPC: res = sh_pc + {ins[31:12], 12'h000};
      rv_pkg::OPC_JAL: begin
        res = sh_pc + 32'd4;
        npc = sh_pc + imm_j;
      end
      rv_pkg::OPC_JALR: begin
        res = sh_pc + 32'd4;
        npc = (a + imm_i) & 32'hffff_fffe;
      end
      rv_pkg::OPC_BRANCH: begin
        wr = 1'b0;
        case (ins[14:12])
          3'd0:    taken = (a == b);
          3'd1:    taken = (a != b);
          3'd4:    taken = ($signed(a) < $signed(b));
          3'd5:    taken = ($signed(a) >= $signed(b));
          3'd6:    taken = (a < b);
          3'd7:    taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (taken) npc = sh_pc + imm_b;
      end
      rv_pkg::OPC_LOAD: begin
        ea             = a + imm_i;
        res            = sh_dmem[ea[7:2]];
        st.read_enable = 1'b1;
        st.addr        = ea;
      end
      rv_pkg::OPC_STORE: begin
        wr               = 1'b0;
        ea               = a + imm_s;
        st.write_enable  = 1'b1;
        st.addr          = ea;
        st.wdata         = b;
        sh_dmem[ea[7:2]] = b;
      end
      rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP: begin
        y   = (ins[6:0] == rv_pkg::OPC_OP) ? b : imm_i;
        // bit 30 means sub for OP only, arithmetic shift for both
        alt = ins[30] && (ins[6:0] == rv_pkg::OPC_OP || ins[14:12] == 3'd5);
        case (ins[14:12])
          3'd0: res = alt ? a - y : a + y;
          3'd1: res = a << y[4:0];
          3'd2: res = {31'b0, $signed(a) < $signed(y)};
          3'd3: res = {31'b0, a < y};
          3'd4: res = a ^ y;
          3'd5: res = (a >> y[4:0]) | ((alt && a[31]) ? ~(32'hffff_ffff >> y[4:0]) : 32'h0);
          3'd6: res = a | y;
          default: res = a & y;
        endcase
      end
      // fence and unknown opcodes
      default: wr = 1'b0;
    endcase
    if (wr && ins[11:7] != 5'd0) sh_regs[ins[11:7]] = res;
  endfunction

  initial begin
    logic [31:0] lfsr;
    logic [31:0] word;
    lfsr = 32'h224310d4;
    word = '0;
    for (int w = 0; w < 64; w++) begin
      for (int k = 0; k < 32; k++) begin
        lfsr = lfsr_step(lfsr);
        word = {word[30:0], lfsr[0]};
      end
      dmem[w[5:0]]    <= word;
      sh_dmem[w[5:0]] = word;
    end
    for (int r = 0; r < 32; r++) sh_regs[r[4:0]] = '0;
    sh_pc     = reset_vector;
    emit_idx  = 8'd64;
    store_off = 12'd0;
    emit(enc_u(20'h80001, 5'd1, rv_pkg::OPC_LUI));
    emit(enc_i(12'hff9, 5'd0, 3'd0, 5'd2, rv_pkg::OPC_OP_IMM));
    emit_store(5'd1);
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(7'h00, 5'd2, 5'd1, f[2:0], 5'd3));
      emit_store(5'd3);
    end
    // sub and sra
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
    emit_store(5'd3);
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3));
    emit_store(5'd3);
    // immediate forms, shifts by 3, compares against +7, srai last
    for (int f = 0; f < 8; f++) begin
      emit(enc_i((f == 1 || f == 5) ? 12'h003 : ((f == 2 || f == 3) ? 12'h007 : 12'hff9),
                 5'd1, f[2:0], 5'd4, rv_pkg::OPC_OP_IMM));
      emit_store(5'd4);
    end
    emit(enc_i(12'h403, 5'd1, 3'd5, 5'd4, rv_pkg::OPC_OP_IMM));
    emit_store(5'd4);
    emit(enc_u(20'h00012, 5'd5, rv_pkg::OPC_AUIPC));
    emit_store(5'd5);
    // each condition on (x1,x1), (x1,x2) and (x1,x0), a taken branch skips the x9 count
    // x1 is negative, so (x1,x0) splits signed from unsigned
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        emit(enc_b(13'd8, 5'd1, 5'd1, f[2:0]));
        emit(enc_i(12'd1, 5'd9, 3'd0, 5'd9, rv_pkg::OPC_OP_IMM));
        emit(enc_b(13'd8, 5'd2, 5'd1, f[2:0]));
        emit(enc_i(12'd1, 5'd9, 3'd0, 5'd9, rv_pkg::OPC_OP_IMM));
        emit(enc_b(13'd8, 5'd0, 5'd1, f[2:0]));
        emit(enc_i(12'd1, 5'd9, 3'd0, 5'd9, rv_pkg::OPC_OP_IMM));
      end
    end
    emit_store(5'd9);
    // counted loop, three passes
    emit(enc_i(12'd3, 5'd0, 3'd0, 5'd7, rv_pkg::OPC_OP_IMM));
    emit(enc_i(12'hfff, 5'd7, 3'd0, 5'd7, rv_pkg::OPC_OP_IMM));
    emit(enc_b(13'h1ffc, 5'd0, 5'd7, 3'd1));
    emit(enc_j(21'd8, 5'd11));
    emit(enc_i(12'd1, 5'd9, 3'd0, 5'd9, rv_pkg::OPC_OP_IMM));
    emit_store(5'd11);
    // rs1 + 13 lands on auipc + 12 once bit 0 is cleared
    emit(enc_u(20'h0, 5'd12, rv_pkg::OPC_AUIPC));
    emit(enc_i(12'd13, 5'd12, 3'd0, 5'd13, rv_pkg::OPC_JALR));
    emit(enc_i(12'd1, 5'd9, 3'd0, 5'd9, rv_pkg::OPC_OP_IMM));
    emit_store(5'd13);
    emit_store(5'd9);
    emit(enc_i(12'd200, 5'd0, 3'd2, 5'd15, rv_pkg::OPC_LOAD));
    emit(enc_s(12'd200, 5'd15, 5'd0));
    emit(enc_i(12'd5, 5'd0, 3'd0, 5'd0, rv_pkg::OPC_OP_IMM));
    emit_store(5'd0);
    // fence, then an opcode the core does not know, then spin
    emit(32'h0000_000f);
    emit(32'h0000_007f);
    emit(enc_j(21'd0, 5'd0));
  end

  // compare at the falling edge, when pc and requests have settled
  initial begin : compare
    logic [31:0]       npc;
    rv_pkg::dmem_req_t st;
    for (int waited = 0; arst_n !== 1'b1; waited++) begin
      if (waited == 10) abort_run("reset was not released within 10 cycles");
      @(negedge clock);
    end
    for (int step = 0; step < num_steps; step++) begin
      check_value("inst_addr", inst_addr, sh_pc);
      ref_step(imem[sh_pc[9:2]], npc, st);
      check_value("dmem_req.read_enable", {31'b0, dmem_req.read_enable},
                  {31'b0, st.read_enable});
      check_value("dmem_req.write_enable", {31'b0, dmem_req.write_enable},
                  {31'b0, st.write_enable});
      if (st.read_enable || st.write_enable) begin
        check_value("dmem_req.addr", dmem_req.addr, st.addr);
      end
      if (st.write_enable) begin
        check_value("dmem_req.wdata", dmem_req.wdata, st.wdata);
      end
      sh_pc = npc;
      @(negedge clock);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/core_asserts.sv
//----------------------------------------------------------
// concurrent checks, bound into singlecycle_core
// ctl is the decoder output as seen inside the core
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_asserts (
  input logic              clock,
  input logic              arst_n,
  input logic [31:0]       inst,
  input logic [31:0]       inst_addr,
  input rv_pkg::ctl_t      ctl,
  input rv_pkg::dmem_req_t dmem_req
);

  // one word access per instruction, load or store
  no_read_and_write: assert property (@(posedge clock) disable iff (!arst_n)
    !(dmem_req.read_enable && dmem_req.write_enable))
    else $error("data memory read and write enabled together");

  pc_word_aligned: assert property (@(posedge clock) disable iff (!arst_n)
    inst_addr[1:0] == 2'b00)
    else $error("inst_addr is not word aligned");

  // only jalr takes its target from rs1
  rs1_target_only_jalr: assert property (@(posedge clock) disable iff (!arst_n)
    ctl.next_pc_sel == rv_pkg::PC_RS1_IMM |-> inst[6:0] == rv_pkg::OPC_JALR)
    else $error("rs1-based next pc selected outside jalr");

endmodule

`default_nettype wire

//--- hdl/singlecycle_core.sv
//----------------------------------------------------------
// single-cycle RV32I core, one instruction per clock
// inst and dmem_rdata must be valid in the same cycle
// word loads and stores only, no traps or alignment checks
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module singlecycle_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_vector = 32'h0000_0000
) (
  input  logic                    clock,
  input  logic                    arst_n,
  output logic [rv_pkg::xlen-1:0] inst_addr,
  input  logic [rv_pkg::xlen-1:0] inst,
  output rv_pkg::dmem_req_t       dmem_req,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata
);

  rv_pkg::ctl_t            ctl;
  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] next_pc;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] pc_imm;
  logic [rv_pkg::xlen-1:0] imm;
  logic [rv_pkg::xlen-1:0] rdata1;
  logic [rv_pkg::xlen-1:0] rdata2;
  logic [rv_pkg::xlen-1:0] alu_a;
  logic [rv_pkg::xlen-1:0] alu_b;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [rv_pkg::xlen-1:0] wb_data;
  logic                    take_branch;

  singlecycle_control control_i (
    .opcode     (inst[6:0]),
    .take_branch(take_branch),
    .ctl        (ctl)
  );

  imm_gen imm_gen_i (.inst(inst), .imm(imm));

  regfile regfile_i (
    .clock       (clock),
    .arst_n      (arst_n),
    .rs1         (inst[19:15]),
    .rs2         (inst[24:20]),
    .rd          (inst[11:7]),
    .write_enable(ctl.regfile_write_enable),
    .wdata       (wb_data),
    .rdata1      (rdata1),
    .rdata2      (rdata2)
  );

  branch_unit branch_unit_i (
    .funct3     (inst[14:12]),
    .a          (rdata1),
    .b          (rdata2),
    .take_branch(take_branch)
  );

  assign alu_a = (ctl.alu_a_sel == rv_pkg::ALU_A_PC) ? pc : rdata1;
  assign alu_b = (ctl.alu_b_sel == rv_pkg::ALU_B_IMM) ? imm : rdata2;

  alu alu_i (
    .alu_class(ctl.alu_class),
    .funct3   (inst[14:12]),
    .funct7_5 (inst[30]),
    .a        (alu_a),
    .b        (alu_b),
    .result   (alu_result)
  );

  always_comb begin
    case (ctl.wb_sel)
      rv_pkg::WB_IMM:  wb_data = imm;
      rv_pkg::WB_PC4:  wb_data = pc_plus4;
      rv_pkg::WB_DATA: wb_data = dmem_rdata;
      default:         wb_data = alu_result;
    endcase
  end

  assign pc_plus4 = pc + 32'd4;
  assign pc_imm   = pc + imm;

  // for jalr the alu already holds rs1 + imm
  always_comb begin
    case (ctl.next_pc_sel)
      rv_pkg::PC_PC_IMM:  next_pc = pc_imm;
      rv_pkg::PC_RS1_IMM: next_pc = {alu_result[rv_pkg::xlen-1:1], 1'b0};
      default:            next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) pc <= reset_vector;
    else pc <= next_pc;
  end

  assign inst_addr             = pc;
  assign dmem_req.read_enable  = ctl.data_mem_read_enable;
  assign dmem_req.write_enable = ctl.data_mem_write_enable;
  assign dmem_req.addr         = alu_result;
  assign dmem_req.wdata        = rdata2;

endmodule

`default_nettype wire

//--- hdl/branch_unit.sv
//----------------------------------------------------------
// branch condition from funct3, reserved codes never taken
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  logic [2:0]              funct3,
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  output logic                    take_branch
);

  always_comb begin
    case (funct3)
      3'b000:  take_branch = (a == b);
      3'b001:  take_branch = (a != b);
      3'b100:  take_branch = ($signed(a) < $signed(b));
      3'b101:  take_branch = ($signed(a) >= $signed(b));
      3'b110:  take_branch = (a < b);
      3'b111:  take_branch = (a >= b);
      // 010 and 011 are reserved
      default: take_branch = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/imm_gen.sv
//----------------------------------------------------------
// immediate decode for I, S, B, U and J formats
// opcodes without an immediate fall back to I-type
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  logic [rv_pkg::xlen-1:0] inst,
  output logic [rv_pkg::xlen-1:0] imm
);

  always_comb begin
    case (inst[6:0])
      rv_pkg::OPC_STORE:
        imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
      rv_pkg::OPC_BRANCH:
        imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      // U-type, upper 20 bits
      rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC:
        imm = {inst[31:12], 12'b0};
      rv_pkg::OPC_JAL:
        imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      // loads, op-imm, jalr
      default:
        imm = {{21{inst[31]}}, inst[30:20]};
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/regfile.sv
//----------------------------------------------------------
// 32 x 32 register file, combinational reads
// x0 reads as zero, writes to it are dropped
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic                    clock,
  input  logic                    arst_n,
  input  logic [4:0]              rs1,
  input  logic [4:0]              rs2,
  input  logic [4:0]              rd,
  input  logic                    write_enable,
  input  logic [rv_pkg::xlen-1:0] wdata,
  output logic [rv_pkg::xlen-1:0] rdata1,
  output logic [rv_pkg::xlen-1:0] rdata2
);

  logic [rv_pkg::xlen-1:0] regs [32];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (write_enable && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- hdl/alu.sv
//----------------------------------------------------------
// alu, combinational
// shift amount is the low 5 bits of operand b
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  rv_pkg::alu_class_e          alu_class,
  input  logic [2:0]                  funct3,
  input  logic                        funct7_5,
  input  logic [rv_pkg::xlen-1:0]     a,
  input  logic [rv_pkg::xlen-1:0]     b,
  output logic [rv_pkg::xlen-1:0]     result
);

  logic [4:0]              shamt;
  logic [rv_pkg::xlen-1:0] sum;
  logic [rv_pkg::xlen-1:0] sra_result;

  assign shamt = b[4:0];
  assign sum   = a + b;
  // kept apart so the shift stays signed
  assign sra_result = $signed(a) >>> shamt;

  always_comb begin
    case (alu_class)
      // branch compares live in branch_unit, sum is ignored there
      rv_pkg::ALU_ADD, rv_pkg::ALU_BRANCH: result = sum;
      default: begin
        case (funct3)
          3'b000: begin
            // sub only exists for register-register ops
            if (alu_class == rv_pkg::ALU_OP && funct7_5) result = a - b;
            else result = sum;
          end
          3'b001: result = a << shamt;
          3'b010: result = {{(rv_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
          3'b011: result = {{(rv_pkg::xlen-1){1'b0}}, a < b};
          3'b100: result = a ^ b;
          3'b101: result = funct7_5 ? sra_result : (a >> shamt);
          3'b110: result = a | b;
          default: result = a & b;
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/singlecycle_control.sv
//----------------------------------------------------------
// opcode decoder, purely combinational
// unknown opcodes decode as a no-op: no write, pc + 4
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module singlecycle_control (
  input  logic [6:0]   opcode,
  input  logic         take_branch,
  output rv_pkg::ctl_t ctl
);

  always_comb begin
    // no-op defaults, overridden per opcode
    ctl.regfile_write_enable  = 1'b0;
    ctl.alu_a_sel             = rv_pkg::ALU_A_RS1;
    ctl.alu_b_sel             = rv_pkg::ALU_B_RS2;
    ctl.alu_class             = rv_pkg::ALU_ADD;
    ctl.data_mem_read_enable  = 1'b0;
    ctl.data_mem_write_enable = 1'b0;
    ctl.wb_sel                = rv_pkg::WB_ALU;
    ctl.next_pc_sel           = rv_pkg::PC_PC4;

    case (opcode)
      rv_pkg::OPC_LOAD: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_b_sel            = rv_pkg::ALU_B_IMM;
        ctl.data_mem_read_enable = 1'b1;
        ctl.wb_sel               = rv_pkg::WB_DATA;
      end
      rv_pkg::OPC_STORE: begin
        ctl.alu_b_sel             = rv_pkg::ALU_B_IMM;
        ctl.data_mem_write_enable = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_b_sel            = rv_pkg::ALU_B_IMM;
        ctl.alu_class            = rv_pkg::ALU_OP_IMM;
      end
      rv_pkg::OPC_OP: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_class            = rv_pkg::ALU_OP;
      end
      rv_pkg::OPC_AUIPC: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_a_sel            = rv_pkg::ALU_A_PC;
        ctl.alu_b_sel            = rv_pkg::ALU_B_IMM;
      end
      // immediate is already shifted into place
      rv_pkg::OPC_LUI: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.wb_sel               = rv_pkg::WB_IMM;
      end
      rv_pkg::OPC_BRANCH: begin
        ctl.alu_class   = rv_pkg::ALU_BRANCH;
        ctl.next_pc_sel = take_branch ? rv_pkg::PC_PC_IMM : rv_pkg::PC_PC4;
      end
      rv_pkg::OPC_JAL: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_a_sel            = rv_pkg::ALU_A_PC;
        ctl.alu_b_sel            = rv_pkg::ALU_B_IMM;
        ctl.wb_sel               = rv_pkg::WB_PC4;
        ctl.next_pc_sel          = rv_pkg::PC_PC_IMM;
      end
      rv_pkg::OPC_JALR: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_b_sel            = rv_pkg::ALU_B_IMM;
        ctl.wb_sel               = rv_pkg::WB_PC4;
        ctl.next_pc_sel          = rv_pkg::PC_RS1_IMM;
      end
      // fence has nothing to order in a single-cycle core
      rv_pkg::OPC_MISC_MEM: ;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/rv_pkg.sv
//----------------------------------------------------------
// shared types for the single-cycle RV32I core
// datapath is fixed at 32 bits, so xlen is not a parameter
//----------------------------------------------------------
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111
  } opcode_e;

  typedef enum logic {
    ALU_A_RS1 = 1'b0,
    ALU_A_PC  = 1'b1
  } alu_a_sel_e;

  typedef enum logic {
    ALU_B_RS2 = 1'b0,
    ALU_B_IMM = 1'b1
  } alu_b_sel_e;

  // how the alu reads funct3 and funct7
  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_OP     = 2'd1,
    ALU_OP_IMM = 2'd2,
    ALU_BRANCH = 2'd3
  } alu_class_e;

  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_IMM  = 2'd1,
    WB_PC4  = 2'd2,
    WB_DATA = 2'd3
  } wb_sel_e;

  typedef enum logic [1:0] {
    PC_PC4     = 2'd0,
    PC_PC_IMM  = 2'd1,
    PC_RS1_IMM = 2'd2
  } next_pc_e;

  typedef struct packed {
    logic       regfile_write_enable;
    alu_a_sel_e alu_a_sel;
    alu_b_sel_e alu_b_sel;
    alu_class_e alu_class;
    logic       data_mem_read_enable;
    logic       data_mem_write_enable;
    wb_sel_e    wb_sel;
    next_pc_e   next_pc_sel;
  } ctl_t;

  // word-wide data memory request, read data comes back combinationally
  typedef struct packed {
    logic            read_enable;
    logic            write_enable;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
  } dmem_req_t;

endpackage

`default_nettype wire
